// File: flist.f
logic/fpu_misc_pkg.sv
logic/fpu_classify.sv
logic/fpu_ordered_cmp.sv
logic/fpu_fmin_fmax.sv
logic/fpu_fcmp.sv
logic/fpu_misc_out.sv
logic/fpu_misc_top.sv
test/fpu_misc_tb.sv

// File: logic/fpu_classify.sv
// ieee operand classifier
`timescale 1ns/1ps
`default_nettype none

module fpu_classify #(
  parameter int exp_width_p = 8,
  // counts the hidden bit
  parameter int sig_width_p = 24,
  localparam int width_lp = exp_width_p + sig_width_p
) (
  input  logic [width_lp-1:0]     fp_i,
  output fpu_misc_pkg::fp_class_s class_o
);

  // field split
  logic                   sign;
  logic [exp_width_p-1:0] exp_field;
  logic [sig_width_p-2:0] frac_field;

  assign sign       = fp_i[width_lp-1];
  assign exp_field  = fp_i[width_lp-2 -: exp_width_p];
  assign frac_field = fp_i[sig_width_p-2:0];

  // exponent and fraction summaries
  logic exp_all_ones;
  logic exp_all_zero;
  logic frac_zero;

  assign exp_all_ones = &exp_field;
  assign exp_all_zero = ~|exp_field;
  assign frac_zero    = ~|frac_field;

  // --------------------
  // class bits
  // --------------------

  always_comb begin
    class_o.sign    = sign;
    // subnormals are not zero
    class_o.is_zero = exp_all_zero & frac_zero;
    class_o.is_inf  = exp_all_ones & frac_zero;
    class_o.is_nan  = exp_all_ones & ~frac_zero;
    // quiet bit is the msb of the fraction
    class_o.is_snan = exp_all_ones & ~frac_zero & ~frac_field[sig_width_p-2];
  end

endmodule

`default_nettype wire

// File: logic/fpu_fcmp.sv
// feq / flt / fle comparator
`timescale 1ns/1ps
`default_nettype none

module fpu_fcmp #(
  parameter int exp_width_p = 8,
  parameter int sig_width_p = 24,
  localparam int width_lp = exp_width_p + sig_width_p
) (
  input  logic [width_lp-1:0]        fp_rs1_i,
  input  logic [width_lp-1:0]        fp_rs2_i,
  input  fpu_misc_pkg::fp_class_s    rs1_class_i,
  input  fpu_misc_pkg::fp_class_s    rs2_class_i,
  input  fpu_misc_pkg::fpu_misc_op_e op_i,
  output logic                       cmp_o,
  output fpu_misc_pkg::fpu_flags_s   flags_o
);

  logic cmp_lt;
  logic cmp_eq;

  fpu_ordered_cmp #(
    .exp_width_p(exp_width_p),
    .sig_width_p(sig_width_p)
  ) ordered_cmp_inst (
    .a_i       (fp_rs1_i),
    .b_i       (fp_rs2_i),
    .a_class_i (rs1_class_i),
    .b_class_i (rs2_class_i),
    .lt_o      (cmp_lt),
    .eq_o      (cmp_eq)
  );

  // nan summaries
  logic any_nan;
  logic any_snan;
  logic signaling;
  logic cmp_raw;

  assign any_nan   = rs1_class_i.is_nan | rs2_class_i.is_nan;
  assign any_snan  = rs1_class_i.is_snan | rs2_class_i.is_snan;
  // flt and fle trap on quiet nans too
  assign signaling = (op_i == fpu_misc_pkg::e_flt) | (op_i == fpu_misc_pkg::e_fle);

  // --------------------
  // ordered result
  // --------------------

  always_comb begin
    case (op_i)
      fpu_misc_pkg::e_feq: cmp_raw = cmp_eq;
      fpu_misc_pkg::e_flt: cmp_raw = cmp_lt;
      fpu_misc_pkg::e_fle: cmp_raw = cmp_lt | cmp_eq;
      default:             cmp_raw = 1'b0;
    endcase
  end

  // unordered always compares false
  assign cmp_o = cmp_raw & ~any_nan;

  always_comb begin
    flags_o         = '0;
    flags_o.invalid = signaling ? any_nan : any_snan;
  end

  // nan seen directly on the operand words
  logic rs1_nan_bits;
  logic rs2_nan_bits;

  assign rs1_nan_bits = (&fp_rs1_i[width_lp-2 -: exp_width_p])
                        & (|fp_rs1_i[sig_width_p-2:0]);
  assign rs2_nan_bits = (&fp_rs2_i[width_lp-2 -: exp_width_p])
                        & (|fp_rs2_i[sig_width_p-2:0]);

  always_comb begin
    if (rs1_nan_bits | rs2_nan_bits) begin
      assert final (!cmp_o) else $error("compare true with a nan operand");
    end
  end

endmodule

`default_nettype wire

// File: logic/fpu_fmin_fmax.sv
// fmin / fmax selector
`timescale 1ns/1ps
`default_nettype none

module fpu_fmin_fmax #(
  parameter int exp_width_p = 8,
  parameter int sig_width_p = 24,
  localparam int width_lp = exp_width_p + sig_width_p
) (
  input  logic [width_lp-1:0]      fp_rs1_i,
  input  logic [width_lp-1:0]      fp_rs2_i,
  input  fpu_misc_pkg::fp_class_s  rs1_class_i,
  input  fpu_misc_pkg::fp_class_s  rs2_class_i,
  // 1 = fmin, 0 = fmax
  input  logic                     fmin_not_fmax_i,
  output logic [width_lp-1:0]      result_o,
  output fpu_misc_pkg::fpu_flags_s flags_o
);

  // canonical nan: +, exp all ones, quiet bit only
  localparam logic [width_lp-1:0] canonical_nan_lp =
    {1'b0, {exp_width_p{1'b1}}, 1'b1, {(sig_width_p-2){1'b0}}};

  logic cmp_lt;
  logic cmp_eq;

  fpu_ordered_cmp #(
    .exp_width_p(exp_width_p),
    .sig_width_p(sig_width_p)
  ) ordered_cmp_inst (
    .a_i       (fp_rs1_i),
    .b_i       (fp_rs2_i),
    .a_class_i (rs1_class_i),
    .b_class_i (rs2_class_i),
    .lt_o      (cmp_lt),
    .eq_o      (cmp_eq)
  );

  // equal with differing signs only happens for +0 / -0
  logic zero_diff_sign;
  assign zero_diff_sign = cmp_eq & (rs1_class_i.sign ^ rs2_class_i.sign);

  // --------------------
  // result select
  // --------------------

  always_comb begin
    if (rs1_class_i.is_nan & rs2_class_i.is_nan) begin
      result_o = canonical_nan_lp;
    end else if (rs1_class_i.is_nan) begin
      result_o = fp_rs2_i;
    end else if (rs2_class_i.is_nan) begin
      result_o = fp_rs1_i;
    end else if (zero_diff_sign) begin
      // min takes the -0, max takes the +0
      result_o = (fmin_not_fmax_i ^ rs1_class_i.sign) ? fp_rs2_i : fp_rs1_i;
    end else begin
      // rs1 wins when lt matches min
      result_o = (cmp_lt ^ fmin_not_fmax_i) ? fp_rs2_i : fp_rs1_i;
    end
  end

  // snan raises nv even if a number comes out
  always_comb begin
    flags_o         = '0;
    flags_o.invalid = rs1_class_i.is_snan | rs2_class_i.is_snan;
  end

  // nan seen directly on the operand words
  logic rs1_nan_bits;
  logic rs2_nan_bits;

  assign rs1_nan_bits = (&fp_rs1_i[width_lp-2 -: exp_width_p])
                        & (|fp_rs1_i[sig_width_p-2:0]);
  assign rs2_nan_bits = (&fp_rs2_i[width_lp-2 -: exp_width_p])
                        & (|fp_rs2_i[sig_width_p-2:0]);

  // canonical nan only for two nans, otherwise a non-nan operand
  always_comb begin
    if (!$isunknown({fp_rs1_i, fp_rs2_i, fmin_not_fmax_i})) begin
      if (rs1_nan_bits & rs2_nan_bits) begin
        assert final (result_o == canonical_nan_lp)
          else $error("fmin/fmax on two nans is not the canonical nan");
      end else begin
        assert final (((result_o == fp_rs1_i) && !rs1_nan_bits)
                      || ((result_o == fp_rs2_i) && !rs2_nan_bits))
          else $error("fmin/fmax result is not a non-nan operand");
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/fpu_misc_out.sv
// result select and output register
`timescale 1ns/1ps
`default_nettype none

module fpu_misc_out #(
  parameter int exp_width_p = 8,
  parameter int sig_width_p = 24,
  localparam int width_lp = exp_width_p + sig_width_p
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       v_i,
  input  fpu_misc_pkg::fpu_misc_op_e op_i,
  input  logic [width_lp-1:0]        minmax_i,
  input  fpu_misc_pkg::fpu_flags_s   minmax_flags_i,
  input  logic                       cmp_i,
  input  fpu_misc_pkg::fpu_flags_s   cmp_flags_i,
  output logic                       v_o,
  output logic [width_lp-1:0]        result_o,
  output fpu_misc_pkg::fpu_flags_s   flags_o
);

  // --------------------
  // opcode select
  // --------------------

  logic [width_lp-1:0]      result_n;
  fpu_misc_pkg::fpu_flags_s flags_n;

  always_comb begin
    case (op_i)
      fpu_misc_pkg::e_fmin,
      fpu_misc_pkg::e_fmax: begin
        result_n = minmax_i;
        flags_n  = minmax_flags_i;
      end
      default: begin
        // compare bit lands in the lsb
        result_n = {{(width_lp-1){1'b0}}, cmp_i};
        flags_n  = cmp_flags_i;
      end
    endcase
  end

  // --------------------
  // registers
  // --------------------

  // valid pulse, one cycle per v_i
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i;
    end
  end

  // payload holds while idle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o <= '0;
      flags_o  <= '0;
    end else if (v_i) begin
      result_o <= result_n;
      flags_o  <= flags_n;
    end
  end

  // payload only moves together with a valid pulse
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !v_o |-> ($stable(result_o) && $stable(flags_o)))
    else $error("result_o or flags_o changed without v_o");

endmodule

`default_nettype wire

// File: logic/fpu_misc_pkg.sv
// fpu min/max and compare
// shared types
`default_nettype none

package fpu_misc_pkg;

  // --------------------
  // opcodes
  // --------------------

  // 3-bit encoding, values 5..7 unused
  typedef enum logic [2:0] {
    e_fmin = 3'd0,
    e_fmax = 3'd1,
    e_feq  = 3'd2,
    e_flt  = 3'd3,
    e_fle  = 3'd4
  } fpu_misc_op_e;

  // --------------------
  // operand class
  // --------------------

  // one decoded ieee operand
  typedef struct packed {
    // raw sign bit
    logic sign;
    // +0 or -0
    logic is_zero;
    // +inf or -inf
    logic is_inf;
    // any nan, quiet or signaling
    logic is_nan;
    // nan with top fraction bit clear
    logic is_snan;
  } fp_class_s;

  // --------------------
  // exception flags
  // --------------------

  // only nv for now
  // room for nx, uf, of, dz later
  typedef struct packed {
    logic invalid;
  } fpu_flags_s;

endpackage

`default_nettype wire

// File: logic/fpu_misc_top.sv
// fpu min/max and compare unit
`timescale 1ns/1ps
`default_nettype none

module fpu_misc_top #(
  parameter int exp_width_p = 8,
  parameter int sig_width_p = 24,
  localparam int width_lp = exp_width_p + sig_width_p
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       v_i,
  input  fpu_misc_pkg::fpu_misc_op_e op_i,
  input  logic [width_lp-1:0]        fp_rs1_i,
  input  logic [width_lp-1:0]        fp_rs2_i,
  output logic                       v_o,
  output logic [width_lp-1:0]        result_o,
  output fpu_misc_pkg::fpu_flags_s   flags_o
);

  // --------------------
  // classify
  // --------------------

  fpu_misc_pkg::fp_class_s rs1_class;
  fpu_misc_pkg::fp_class_s rs2_class;

  fpu_classify #(
    .exp_width_p(exp_width_p),
    .sig_width_p(sig_width_p)
  ) classify_rs1_inst (
    .fp_i    (fp_rs1_i),
    .class_o (rs1_class)
  );

  fpu_classify #(
    .exp_width_p(exp_width_p),
    .sig_width_p(sig_width_p)
  ) classify_rs2_inst (
    .fp_i    (fp_rs2_i),
    .class_o (rs2_class)
  );

  // --------------------
  // parallel units
  // --------------------

  logic                     fmin_not_fmax;
  logic [width_lp-1:0]      minmax_result;
  fpu_misc_pkg::fpu_flags_s minmax_flags;
  logic                     cmp_result;
  fpu_misc_pkg::fpu_flags_s cmp_flags;

  // anything but fmin runs as fmax, out stage ignores it for compares
  assign fmin_not_fmax = (op_i == fpu_misc_pkg::e_fmin);

  fpu_fmin_fmax #(
    .exp_width_p(exp_width_p),
    .sig_width_p(sig_width_p)
  ) fmin_fmax_inst (
    .fp_rs1_i        (fp_rs1_i),
    .fp_rs2_i        (fp_rs2_i),
    .rs1_class_i     (rs1_class),
    .rs2_class_i     (rs2_class),
    .fmin_not_fmax_i (fmin_not_fmax),
    .result_o        (minmax_result),
    .flags_o         (minmax_flags)
  );

  fpu_fcmp #(
    .exp_width_p(exp_width_p),
    .sig_width_p(sig_width_p)
  ) fcmp_inst (
    .fp_rs1_i    (fp_rs1_i),
    .fp_rs2_i    (fp_rs2_i),
    .rs1_class_i (rs1_class),
    .rs2_class_i (rs2_class),
    .op_i        (op_i),
    .cmp_o       (cmp_result),
    .flags_o     (cmp_flags)
  );

  // select and register, 1 cycle
  fpu_misc_out #(
    .exp_width_p(exp_width_p),
    .sig_width_p(sig_width_p)
  ) out_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .v_i            (v_i),
    .op_i           (op_i),
    .minmax_i       (minmax_result),
    .minmax_flags_i (minmax_flags),
    .cmp_i          (cmp_result),
    .cmp_flags_i    (cmp_flags),
    .v_o            (v_o),
    .result_o       (result_o),
    .flags_o        (flags_o)
  );

endmodule

`default_nettype wire

// File: logic/fpu_ordered_cmp.sv
// ordered compare for non-nan operands
`timescale 1ns/1ps
`default_nettype none

module fpu_ordered_cmp #(
  parameter int exp_width_p = 8,
  parameter int sig_width_p = 24,
  localparam int width_lp = exp_width_p + sig_width_p
) (
  input  logic [width_lp-1:0]     a_i,
  input  logic [width_lp-1:0]     b_i,
  input  fpu_misc_pkg::fp_class_s a_class_i,
  input  fpu_misc_pkg::fp_class_s b_class_i,
  output logic                    lt_o,
  output logic                    eq_o
);

  // magnitude without sign, ieee order matches integer order
  logic [width_lp-2:0] a_mag;
  logic [width_lp-2:0] b_mag;
  logic                both_zero;

  assign a_mag     = a_i[width_lp-2:0];
  assign b_mag     = b_i[width_lp-2:0];
  assign both_zero = a_class_i.is_zero & b_class_i.is_zero;

  // +0 == -0 here, callers sort out the sign
  assign eq_o = (a_i == b_i) | both_zero;

  // --------------------
  // less-than
  // --------------------

  always_comb begin
    if (both_zero) begin
      lt_o = 1'b0;
    end else if (a_class_i.sign != b_class_i.sign) begin
      // negative side is smaller
      lt_o = a_class_i.sign;
    end else if (a_class_i.sign) begin
      // both negative, order flips
      lt_o = a_mag > b_mag;
    end else begin
      lt_o = a_mag < b_mag;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fpu min/max and compare testbench with verilator

cd "$(dirname "$0")" || exit 1

mkdir -p build

verilator --binary --timing --assert \
  -f flist.f \
  --top-module fpu_misc_tb \
  -Mdir build/obj_dir \
  -o fpu_misc_sim > build/compile.log 2>&1 \
  || { echo "compile failed, see build/compile.log"; exit 1; }

./build/obj_dir/fpu_misc_sim > build/sim.log 2>&1 \
  || { echo "simulation ended with an error, see build/sim.log"; }

grep -qx "TB PASSED" build/sim.log \
  && echo "result: pass" \
  || { echo "result: fail, see build/sim.log"; exit 1; }

// File: test/fpu_misc_tb.sv
// fpu min/max and compare testbench
`timescale 1ns/1ps
`default_nettype none

module fpu_misc_tb;

  // op counts for the timeout budget
  localparam int directed_ops_lp = 34;
  localparam int random_ops_lp   = 300;
  localparam int timeout_lp      = 4 * (directed_ops_lp + random_ops_lp) + 50;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       v_i;
  fpu_misc_pkg::fpu_misc_op_e op_i;
  logic [31:0]                fp_rs1_i;
  logic [31:0]                fp_rs2_i;
  logic                       v_o;
  logic [31:0]                result_o;
  fpu_misc_pkg::fpu_flags_s   flags_o;
  int                         cycle_count;

  fpu_misc_top #(
    .exp_width_p(8),
    .sig_width_p(24)
  ) fpu_misc_top_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .op_i     (op_i),
    .fp_rs1_i (fp_rs1_i),
    .fp_rs2_i (fp_rs2_i),
    .v_o      (v_o),
    .result_o (result_o),
    .flags_o  (flags_o)
  );

  // --------------------
  // clock and timeout
  // --------------------

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_lp) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_lp);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // reference model, binary32
  // --------------------

  function automatic bit is_nan32(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // quiet bit clear
  function automatic bit is_snan32(input logic [31:0] x);
    return is_nan32(x) && !x[22];
  endfunction

  // signed order key, both zeros map to 0
  function automatic logic signed [32:0] order_key(input logic [31:0] x);
    logic signed [32:0] mag;
    mag = $signed({2'b00, x[30:0]});
    return x[31] ? -mag : mag;
  endfunction

  // returns {invalid, result}
  function automatic logic [32:0] model_op(input fpu_misc_pkg::fpu_misc_op_e op,
                                           input logic [31:0] a, input logic [31:0] b);
    bit                 any_nan;
    bit                 any_snan;
    bit                 is_min;
    logic signed [32:0] ka;
    logic signed [32:0] kb;
    logic [31:0]        res;
    any_nan  = is_nan32(a) || is_nan32(b);
    any_snan = is_snan32(a) || is_snan32(b);
    is_min   = (op == fpu_misc_pkg::e_fmin);
    ka       = order_key(a);
    kb       = order_key(b);
    case (op)
      fpu_misc_pkg::e_fmin,
      fpu_misc_pkg::e_fmax: begin
        if (is_nan32(a) && is_nan32(b)) res = 32'h7fc00000;
        else if (is_nan32(a)) res = b;
        else if (is_nan32(b)) res = a;
        else if (ka == kb) begin
          // +0 vs -0, min wants the negative one
          res = (a[31] == is_min) ? a : b;
        end
        else if (is_min) res = (ka < kb) ? a : b;
        else res = (ka > kb) ? a : b;
        return {any_snan, res};
      end
      fpu_misc_pkg::e_feq: return {any_snan, 31'd0, !any_nan && (ka == kb)};
      fpu_misc_pkg::e_flt: return {any_nan, 31'd0, !any_nan && (ka < kb)};
      default:             return {any_nan, 31'd0, !any_nan && (ka <= kb)};
    endcase
  endfunction

  // --------------------
  // check and drive helpers
  // --------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_response(input fpu_misc_pkg::fpu_misc_op_e op,
                                input logic [31:0] a, input logic [31:0] b);
    logic [32:0] exp_v;
    exp_v = model_op(op, a, b);
    check_value("v_o", 32'(v_o), 32'd1);
    check_value("result_o", result_o, exp_v[31:0]);
    check_value("flags_o.invalid", 32'(flags_o.invalid), 32'(exp_v[32]));
  endtask

  // called on a falling edge
  task automatic drive_op(input fpu_misc_pkg::fpu_misc_op_e op,
                          input logic [31:0] a, input logic [31:0] b);
    v_i      = 1'b1;
    op_i     = op;
    fp_rs1_i = a;
    fp_rs2_i = b;
  endtask

  // one op, wait for v_o, check
  task automatic run_op(input fpu_misc_pkg::fpu_misc_op_e op,
                        input logic [31:0] a, input logic [31:0] b);
    int wait_cycles;
    drive_op(op, a, b);
    @(negedge clk_i);
    v_i         = 1'b0;
    wait_cycles = 1;
    while (!v_o) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    check_value("latency", 32'(wait_cycles), 32'd1);
    check_response(op, a, b);
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic minmax_ordinary_test();
    run_op(fpu_misc_pkg::e_fmin, 32'h3f800000, 32'h40000000);
    run_op(fpu_misc_pkg::e_fmax, 32'h3f800000, 32'h40000000);
    run_op(fpu_misc_pkg::e_fmin, 32'hbf800000, 32'hc0000000);
    run_op(fpu_misc_pkg::e_fmax, 32'hbf800000, 32'hc0000000);
    run_op(fpu_misc_pkg::e_fmin, 32'h3f000000, 32'hbf800000);
    run_op(fpu_misc_pkg::e_fmax, 32'hbf800000, 32'h3f000000);
    // infinities
    run_op(fpu_misc_pkg::e_fmin, 32'h7f800000, 32'hff800000);
    run_op(fpu_misc_pkg::e_fmax, 32'hff800000, 32'h40000000);
  endtask

  task automatic signed_zero_test();
    run_op(fpu_misc_pkg::e_fmin, 32'h00000000, 32'h80000000);
    run_op(fpu_misc_pkg::e_fmin, 32'h80000000, 32'h00000000);
    run_op(fpu_misc_pkg::e_fmax, 32'h80000000, 32'h00000000);
    run_op(fpu_misc_pkg::e_fmax, 32'h00000000, 32'h80000000);
  endtask

  task automatic minmax_nan_test();
    // one quiet nan
    run_op(fpu_misc_pkg::e_fmin, 32'h7fc00000, 32'h3f800000);
    run_op(fpu_misc_pkg::e_fmax, 32'hbf800000, 32'h7fc12345);
    // two nans, canonical out
    run_op(fpu_misc_pkg::e_fmin, 32'h7fc12345, 32'hffc00001);
    run_op(fpu_misc_pkg::e_fmax, 32'h7f800001, 32'h7fc00000);
    // snan with a number, invalid anyway
    run_op(fpu_misc_pkg::e_fmin, 32'h7f800001, 32'h40000000);
    run_op(fpu_misc_pkg::e_fmax, 32'hbf800000, 32'hffa00000);
  endtask

  task automatic compare_test();
    run_op(fpu_misc_pkg::e_feq, 32'h3f800000, 32'h3f800000);
    run_op(fpu_misc_pkg::e_feq, 32'h3f800000, 32'h40000000);
    run_op(fpu_misc_pkg::e_flt, 32'hbf800000, 32'h3f800000);
    run_op(fpu_misc_pkg::e_flt, 32'h40000000, 32'h40000000);
    run_op(fpu_misc_pkg::e_fle, 32'h40000000, 32'h40000000);
    run_op(fpu_misc_pkg::e_fle, 32'hc0000000, 32'hbf800000);
    // +0 and -0 are equal
    run_op(fpu_misc_pkg::e_feq, 32'h80000000, 32'h00000000);
    run_op(fpu_misc_pkg::e_flt, 32'h80000000, 32'h00000000);
    run_op(fpu_misc_pkg::e_fle, 32'h00000000, 32'h80000000);
    // quiet nan, feq quiet, flt/fle trap
    run_op(fpu_misc_pkg::e_feq, 32'h7fc00000, 32'h7fc00000);
    run_op(fpu_misc_pkg::e_flt, 32'h3f800000, 32'h7fc00000);
    run_op(fpu_misc_pkg::e_fle, 32'h7fc00000, 32'h3f800000);
    run_op(fpu_misc_pkg::e_feq, 32'h7f800001, 32'h3f800000);
  endtask

  // three ops on consecutive cycles, then idle
  task automatic back_to_back_test();
    fpu_misc_pkg::fpu_misc_op_e ops [3];
    logic [31:0]                av [3];
    logic [31:0]                bv [3];
    logic [32:0]                last_v;
    ops[0] = fpu_misc_pkg::e_flt;
    ops[1] = fpu_misc_pkg::e_fmax;
    ops[2] = fpu_misc_pkg::e_feq;
    av[0] = 32'hbf800000;
    av[1] = 32'h40000000;
    av[2] = 32'h7fc00000;
    bv[0] = 32'h3f800000;
    bv[1] = 32'hc0000000;
    bv[2] = 32'h7fc00000;
    for (int i = 0; i < 3; i++) begin
      drive_op(ops[i], av[i], bv[i]);
      @(negedge clk_i);
      check_response(ops[i], av[i], bv[i]);
    end
    // fresh operands with v_i low, outputs keep the last result
    v_i      = 1'b0;
    op_i     = fpu_misc_pkg::e_fmax;
    fp_rs1_i = 32'h7f800001;
    fp_rs2_i = 32'h40000000;
    @(negedge clk_i);
    last_v = model_op(ops[2], av[2], bv[2]);
    check_value("v_o", 32'(v_o), 32'd0);
    check_value("result_o", result_o, last_v[31:0]);
    check_value("flags_o.invalid", 32'(flags_o.invalid), 32'(last_v[32]));
  endtask

  // --------------------
  // random tests
  // --------------------

  function automatic logic [31:0] random_operand();
    logic [31:0] x;
    x = $urandom;
    case ($urandom_range(0, 7))
      // quiet nan
      0: x[30:22] = 9'h1ff;
      // signaling nan, keep fraction non-zero
      1: begin
        x[30:22] = 9'h1fe;
        x[0]     = 1'b1;
      end
      2: x[30:0] = 31'd0;
      3: x[30:0] = 31'h7f800000;
      default: ;
    endcase
    return x;
  endfunction

  task automatic random_test();
    fpu_misc_pkg::fpu_misc_op_e op;
    logic [31:0]                a;
    logic [31:0]                b;
    for (int i = 0; i < random_ops_lp; i++) begin
      op = fpu_misc_pkg::fpu_misc_op_e'(3'($urandom_range(0, 4)));
      a  = random_operand();
      // sometimes identical operands
      b  = ($urandom_range(0, 9) == 0) ? a : random_operand();
      run_op(op, a, b);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    void'($urandom(32'hdec86c51));
    cycle_count = 0;
    arst_n_i    = 1'b0;
    v_i         = 1'b0;
    op_i        = fpu_misc_pkg::e_fmin;
    fp_rs1_i    = 32'd0;
    fp_rs2_i    = 32'd0;
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    // state straight out of reset
    check_value("v_o", 32'(v_o), 32'd0);
    check_value("result_o", result_o, 32'd0);
    check_value("flags_o.invalid", 32'(flags_o.invalid), 32'd0);
    @(negedge clk_i);
    minmax_ordinary_test();
    signed_zero_test();
    minmax_nan_test();
    compare_test();
    back_to_back_test();
    random_test();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
